// ==== include/sram_settings.svh ====
// Bus and SRAM width macros plus window and CTI codes, included by the package and RTL modules
`ifndef SRAM_SETTINGS_SVH
`define SRAM_SETTINGS_SVH

// SRAM chip geometry, IS61WV102416 style part
`define SRAM_DATA_WIDTH 16
`define SRAM_ADDR_WIDTH 20

// Wishbone data and byte address widths
`define WB_DATA_WIDTH 32
`define WB_ADDR_WIDTH 32
// One select bit per bus byte
`define WB_SEL_WIDTH 4

// Bus window that maps onto the SRAM
`define SRAM_BASE_ADDR 32'h0000_0000
// 2M bytes, 1M half-words
`define SRAM_ADDR_SPAN 32'h0020_0000

// Cycle type identifiers, B4 registered feedback
`define WB_CTI_WIDTH 3
`define WB_CTI_CLASSIC      3'b000
`define WB_CTI_INCREMENTING 3'b010
`define WB_CTI_END_OF_BURST 3'b111

// Burst type extension, linear only in this design
`define WB_BTE_WIDTH 2

`endif

// ==== list.f ====
+incdir+include
src/sram_pkg.sv
src/wb_addr_window.sv
src/sram_wb.sv
src/sram_subsys.sv
sim/sram_chip_model.sv
sim/tb_sram_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the Wishbone SRAM bridge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Iinclude --top-module tb_sram_subsys -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_sram_subsys > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi

if ! grep -q "sim passed" "$LOG"; then
    echo "Simulation log holds no result line"
    exit 1
fi

exit 0

// ==== sim/sram_chip_model.sv ====
// Behavioral async SRAM with byte enables and tristate data, a small-depth stand-in for the chip
`timescale 1ns/10ps

module sram_chip_model #(
    parameter int DEPTH_BITS = 12
) (
    input  logic        i_ce_n,
    input  logic        i_oe_n,
    input  logic        i_we_n,
    input  logic        i_lb_n,
    input  logic        i_ub_n,
    input  logic [19:0] i_addr,
    inout  wire  [15:0] io_dq
);

    // Starts cleared, as the testbench reference memory does
    logic [15:0]           mem [0:(1 << DEPTH_BITS)-1] = '{default: '0};
    logic [DEPTH_BITS-1:0] loc;

    // Only the low address bits decode, upper ones alias
    assign loc = i_addr[DEPTH_BITS-1:0];

    // Write is level sensitive while we_n is low
    always @(i_ce_n or i_we_n or i_lb_n or i_ub_n or loc or io_dq) begin
        if (!i_ce_n && !i_we_n) begin
            if (!i_lb_n) begin
                mem[loc][7:0] = io_dq[7:0];
            end
            if (!i_ub_n) begin
                mem[loc][15:8] = io_dq[15:8];
            end
        end
    end

    // Outputs driven when selected, enabled and not writing
    assign io_dq = (!i_ce_n && !i_oe_n && i_we_n) ? mem[loc] : 16'hzzzz;

endmodule

// ==== sim/tb_sram_subsys.sv ====
// Directed testbench for the Wishbone SRAM bridge, run through list.f by the Verilator script
`timescale 1ns/10ps
`include "sram_settings.svh"

module tb_sram_subsys
    import sram_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 50;

    logic        clk;
    logic        rst;
    wb_req_t     req;
    wb_rsp_t     rsp;
    sram_pins_t  sram_pins;
    wire  [15:0] sram_dq;
    int          error_count;
    logic [15:0] lfsr_state;
    // Word-indexed copy of what the SRAM should hold
    logic [31:0] ref_mem [0:2047];

    sram_subsys sram_subsys_inst (
        .i_wb_clk   (clk),
        .i_wb_rst   (rst),
        .i_wb_req   (req),
        .o_wb_rsp   (rsp),
        .o_sram     (sram_pins),
        .io_sram_dq (sram_dq)
    );

    sram_chip_model chip_inst (
        .i_ce_n (sram_pins.ce_n),
        .i_oe_n (sram_pins.oe_n),
        .i_we_n (sram_pins.we_n),
        .i_lb_n (sram_pins.lb_n),
        .i_ub_n (sram_pins.ub_n),
        .i_addr (sram_pins.addr),
        .io_dq  (sram_dq)
    );

    // 40 ns period
    always #20 clk = ~clk;

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("error at %0t ns: %s, got 0x%h, expected 0x%h",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic random_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Expected word after a write with byte selects
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] sel);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    // Polls at falling edges
    // Edges counts the rising edge that samples the response
    task automatic wait_response(output int edges, output logic got_ack, output logic got_err);
        int n;
        n       = 0;
        got_ack = 1'b0;
        got_err = 1'b0;
        while (n < TIMEOUT_CYCLES && !got_ack && !got_err) begin
            @(negedge clk);
            n++;
            got_ack = rsp.ack;
            got_err = rsp.err;
        end
        edges = n + 1;
        if (!got_ack && !got_err) begin
            $display("timeout: no ack or err within %0d cycles at %0t ns", n, $time);
            error_count++;
        end
    endtask

    // Classic cycle with the request held through the edge that samples the response
    task automatic single_access(input logic we, input logic [3:0] sel, input logic [31:0] addr,
                                 input logic [31:0] wdata, output logic [31:0] rdata,
                                 output int edges, output logic got_ack, output logic got_err);
        req.cyc  = 1'b1;
        req.stb  = 1'b1;
        req.we   = we;
        req.cti  = `WB_CTI_CLASSIC;
        req.sel  = sel;
        req.addr = addr;
        req.data = wdata;
        wait_response(edges, got_ack, got_err);
        rdata = rsp.data;
        @(posedge clk);
        @(negedge clk);
        // Response lasts one cycle only
        check_equal({31'd0, rsp.ack}, 32'd0, "ack after accepted cycle");
        check_equal({31'd0, rsp.err}, 32'd0, "err after accepted cycle");
        req.cyc = 1'b0;
        req.stb = 1'b0;
        req.we  = 1'b0;
    endtask

    task automatic reset_values();
        int n;
        n = 0;
        @(negedge clk);
        check_equal({30'd0, rsp.ack, rsp.err}, 32'd0, "ack and err in reset");
        check_equal({31'd0, sram_pins.we_n}, 32'd1, "we_n in reset");
        // DUT holding all ones would fight the zero from the chip
        check_equal({16'd0, sram_dq}, 32'd0, "data bus released in reset");
        // Reset drops on a falling edge, so rising edges see it settled
        while (rst && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (rst) begin
            $display("timeout: reset still asserted after %0d cycles at %0t ns", n, $time);
            error_count++;
        end
        @(negedge clk);
        check_equal({30'd0, rsp.ack, rsp.err}, 32'd0, "ack and err after reset");
        check_equal({31'd0, sram_pins.we_n}, 32'd1, "we_n after reset");
        // Chip always selected with outputs enabled
        check_equal({30'd0, sram_pins.ce_n, sram_pins.oe_n}, 32'd0, "ce_n and oe_n after reset");
        check_equal({16'd0, sram_dq}, 32'd0, "data bus released after reset");
    endtask

    task automatic single_write_read();
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rdata;
        int          edges;
        logic        got_ack;
        logic        got_err;
        random_bits(11, addr);
        addr = {19'd0, addr[10:0], 2'b00};
        random_bits(32, data);
        single_access(1'b1, 4'hF, addr, data, rdata, edges, got_ack, got_err);
        ref_mem[addr[12:2]] = data;
        check_equal({31'd0, got_ack}, 32'd1, "single write ack");
        check_equal(edges, 2, "single write ack edge");
        single_access(1'b0, 4'hF, addr, 32'd0, rdata, edges, got_ack, got_err);
        check_equal({31'd0, got_ack}, 32'd1, "single read ack");
        check_equal(edges, 3, "single read ack edge");
        check_equal(rdata, ref_mem[addr[12:2]], "single read data");
    endtask

    task automatic byte_select_merge();
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rdata;
        logic [3:0]  sels [3];
        int          edges;
        logic        got_ack;
        logic        got_err;
        sels = '{4'b0001, 4'b0110, 4'b1000};
        addr = 32'h0000_0100;
        single_access(1'b1, 4'hF, addr, 32'h1122_3344, rdata, edges, got_ack, got_err);
        ref_mem[addr[12:2]] = 32'h1122_3344;
        foreach (sels[i]) begin
            random_bits(32, data);
            single_access(1'b1, sels[i], addr, data, rdata, edges, got_ack, got_err);
            ref_mem[addr[12:2]] = merge_bytes(ref_mem[addr[12:2]], data, sels[i]);
            single_access(1'b0, 4'hF, addr, 32'd0, rdata, edges, got_ack, got_err);
            check_equal(rdata, ref_mem[addr[12:2]], "byte select read back");
        end
    endtask

    // Incrementing burst of 4 beats with the last one marked end-of-burst
    task automatic burst_access(input logic we, input logic [31:0] start_addr);
        int          edges;
        logic        got_ack;
        logic        got_err;
        logic [31:0] data;
        for (int beat = 0; beat < 4; beat++) begin
            req.cyc  = 1'b1;
            req.stb  = 1'b1;
            req.we   = we;
            req.sel  = 4'hF;
            req.cti  = (beat == 3) ? `WB_CTI_END_OF_BURST : `WB_CTI_INCREMENTING;
            req.addr = start_addr + 32'(beat * 4);
            if (we) begin
                random_bits(32, data);
                req.data = data;
                ref_mem[req.addr[12:2]] = data;
            end
            wait_response(edges, got_ack, got_err);
            check_equal({31'd0, got_ack}, 32'd1, "burst beat ack");
            if (!we) begin
                check_equal(rsp.data, ref_mem[req.addr[12:2]], "burst read data");
            end
            @(posedge clk);
            @(negedge clk);
        end
        req.cyc = 1'b0;
        req.stb = 1'b0;
        req.we  = 1'b0;
    endtask

    task automatic burst_write_read();
        burst_access(1'b1, 32'h0000_0200);
        burst_access(1'b0, 32'h0000_0200);
    endtask

    task automatic out_of_window_err();
        logic [31:0] rdata;
        int          edges;
        logic        got_ack;
        logic        got_err;
        single_access(1'b1, 4'hF, `SRAM_BASE_ADDR + `SRAM_ADDR_SPAN, 32'hDEAD_BEEF,
                      rdata, edges, got_ack, got_err);
        check_equal({31'd0, got_err}, 32'd1, "out of window err");
        check_equal({31'd0, got_ack}, 32'd0, "out of window ack");
        check_equal(edges, 2, "out of window err edge");
        single_access(1'b0, 4'hF, 32'd0, 32'd0, rdata, edges, got_ack, got_err);
        check_equal(rdata, ref_mem[0], "address 0 after out of window write");
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        error_count = 0;
        lfsr_state  = 16'd1367;
        req         = '0;
        // All ones so a DUT drive in reset would show on the bus
        req.data    = '1;
        foreach (ref_mem[i]) begin
            ref_mem[i] = '0;
        end
        fork
            begin
                repeat (5) @(posedge clk);
                @(negedge clk);
                rst = 1'b0;
            end
            reset_values();
        join
        req.data = '0;
        single_write_read();
        byte_select_merge();
        burst_write_read();
        out_of_window_err();
        $display("checks done, %0d errors", error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== src/sram_pkg.sv ====
// Shared bus, SRAM pin and controller state types, imported by every module of the SRAM bridge
`include "sram_settings.svh"

package sram_pkg;

    // Master request as seen by a Wishbone slave
    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [`WB_CTI_WIDTH-1:0]   cti;
        // Accepted but never decoded
        logic [`WB_BTE_WIDTH-1:0]   bte;
        logic [`WB_SEL_WIDTH-1:0]   sel;
        logic [`WB_ADDR_WIDTH-1:0]  addr;
        logic [`WB_DATA_WIDTH-1:0]  data;
    } wb_req_t;

    // Slave response, ack and err are exclusive
    typedef struct packed {
        logic                       ack;
        logic                       err;
        logic [`WB_DATA_WIDTH-1:0]  data;
    } wb_rsp_t;

    // SRAM control pins, all active low except the address
    typedef struct packed {
        logic                        ce_n;
        logic                        oe_n;
        logic                        we_n;
        logic                        lb_n;
        logic                        ub_n;
        logic [`SRAM_ADDR_WIDTH-1:0] addr;
    } sram_pins_t;

    // One bus word, or the two SRAM half-words inside it
    // Half 0 is the low half, little endian
    typedef union packed {
        logic [`WB_DATA_WIDTH-1:0] word;
        logic [`WB_DATA_WIDTH/`SRAM_DATA_WIDTH-1:0][`SRAM_DATA_WIDTH-1:0] half;
    } wb_word_u;

    // Controller FSM states
    typedef enum logic [2:0] {
        IDLE,
        READ_GATHER,
        READ_ACK,
        WRITE_GATHER,
        WRITE_ACK
    } sram_state_e;

endpackage

// ==== src/sram_subsys.sv ====
// Top of the Wishbone SRAM bridge, joining the address window and the controller to the SRAM pins
`timescale 1ns/10ps
`include "sram_settings.svh"

module sram_subsys
    import sram_pkg::*;
(
    input  logic                        i_wb_clk,
    input  logic                        i_wb_rst,
    // Bus master side
    input  wb_req_t                     i_wb_req,
    output wb_rsp_t                     o_wb_rsp,
    // SRAM chip side
    output sram_pins_t                  o_sram,
    inout  wire [`SRAM_DATA_WIDTH-1:0]  io_sram_dq
);

    // Request after the window check, stb cleared outside the window
    wb_req_t win_req;
    // Controller response before err is merged
    wb_rsp_t ctl_rsp;

    // Range check and err response
    wb_addr_window addr_window_inst (
        .i_wb_clk (i_wb_clk),
        .i_wb_rst (i_wb_rst),
        .i_req    (i_wb_req),
        .o_req    (win_req),
        .i_rsp    (ctl_rsp),
        .o_rsp    (o_wb_rsp)
    );

    // Bus word to half-word SRAM accesses
    sram_wb sram_wb_inst (
        .i_wb_clk   (i_wb_clk),
        .i_wb_rst   (i_wb_rst),
        .i_req      (win_req),
        .o_rsp      (ctl_rsp),
        .o_sram     (o_sram),
        .io_sram_dq (io_sram_dq)
    );

endmodule

// ==== src/sram_wb.sv ====
// Wishbone B4 registered feedback slave driving a 16-bit async SRAM, used under the window block
`timescale 1ns/10ps
`include "sram_settings.svh"

module sram_wb
    import sram_pkg::*;
(
    input  logic                        i_wb_clk,
    input  logic                        i_wb_rst,
    // Request already checked against the window
    input  wb_req_t                     i_req,
    output wb_rsp_t                     o_rsp,
    // SRAM control pins
    output sram_pins_t                  o_sram,
    // Shared SRAM data lines
    inout  wire [`SRAM_DATA_WIDTH-1:0]  io_sram_dq
);

    // Half-words per bus word and bytes per half-word
    localparam int HALF_COUNT = `WB_DATA_WIDTH / `SRAM_DATA_WIDTH;
    localparam int HALF_BYTES = `SRAM_DATA_WIDTH / 8;
    localparam int AW         = `SRAM_ADDR_WIDTH;

    sram_state_e                 state_r;
    sram_state_e                 state_next;
    // Selects the half-word on the SRAM this cycle
    logic                        idx_r;
    logic                        idx_next;
    logic                        wb_en;
    logic                        wb_we;
    logic                        burst_more;
    logic                        capture_en;
    logic [HALF_BYTES-1:0]       half_sel;
    logic [AW-1:0]               word_addr;
    logic [AW-1:0]               half_offs;
    wb_word_u                    wdata;
    // Read data assembled half by half
    wb_word_u                    rdata_r;

    // Valid bus cycle
    assign wb_en = i_req.cyc && i_req.stb;
    assign wb_we = wb_en && i_req.we;

    // Another beat follows this ack
    // Anything other than classic or end-of-burst counts as incrementing
    assign burst_more = wb_en
                     && (i_req.cti != `WB_CTI_CLASSIC)
                     && (i_req.cti != `WB_CTI_END_OF_BURST);

    // Write word sliced into halves
    assign wdata.word = i_req.data;

    // Byte selects for the current half
    assign half_sel = i_req.sel[idx_r * HALF_BYTES +: HALF_BYTES];

    // Half-word address of the bus word, bit 0 of the byte address dropped
    assign word_addr = i_req.addr[AW:1];

    // Read ack cycle already fetches half 0 of the next burst word
    // The master only advances the address after this edge
    always_comb begin
        if (state_r == READ_ACK) begin
            half_offs = AW'(HALF_COUNT);
        end else begin
            half_offs = AW'(idx_r);
        end
    end

    // Chip select and output enable held active, as on the board
    // we_n low overrides the outputs during writes
    assign o_sram.ce_n = 1'b0;
    assign o_sram.oe_n = 1'b0;
    assign o_sram.we_n = ~wb_we;
    // Reads fetch both bytes, writes honour the selects
    assign o_sram.lb_n = wb_we ? ~half_sel[0] : 1'b0;
    assign o_sram.ub_n = wb_we ? ~half_sel[1] : 1'b0;
    assign o_sram.addr = word_addr + half_offs;

    // Drive the lines only while writing
    assign io_sram_dq = wb_we ? wdata.half[idx_r] : {`SRAM_DATA_WIDTH{1'bz}};

    // Next state
    // Write: half 0 in the first cycle, half 1 in the ack cycle
    // Read: half 0, then half 1 with ack raised the cycle after
    always_comb begin
        case (state_r)
            IDLE: begin
                if (wb_we) begin
                    state_next = WRITE_ACK;
                end else if (wb_en) begin
                    state_next = READ_GATHER;
                end else begin
                    state_next = IDLE;
                end
            end
            READ_GATHER: begin
                // Master dropped the cycle
                state_next = wb_en ? READ_ACK : IDLE;
            end
            READ_ACK: begin
                state_next = burst_more ? READ_GATHER : IDLE;
            end
            WRITE_GATHER: begin
                state_next = wb_en ? WRITE_ACK : IDLE;
            end
            WRITE_ACK: begin
                state_next = burst_more ? WRITE_GATHER : IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // Half 1 is on the SRAM in read gather and write ack
    assign idx_next = (state_next == READ_GATHER) || (state_next == WRITE_ACK);

    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            state_r <= IDLE;
            idx_r   <= 1'b0;
        end else begin
            state_r <= state_next;
            idx_r   <= idx_next;
        end
    end

    // Capture read halves
    // Ack cycle captures only when a burst beat follows, keeping data stable otherwise
    assign capture_en = (state_r == IDLE && wb_en && !i_req.we)
                     || (state_r == READ_GATHER)
                     || (state_r == READ_ACK && burst_more);

    always_ff @(posedge i_wb_clk) begin
        if (capture_en) begin
            rdata_r.half[idx_r] <= io_sram_dq;
        end
    end

    // Ack follows the state register, one cycle per beat
    assign o_rsp.ack  = (state_r == READ_ACK) || (state_r == WRITE_ACK);
    // Range errors come from the window
    assign o_rsp.err  = 1'b0;
    assign o_rsp.data = rdata_r.word;

endmodule

// ==== src/wb_addr_window.sv ====
// Wishbone address window in front of the SRAM controller, answers out-of-window strobes with err
`timescale 1ns/10ps
`include "sram_settings.svh"

module wb_addr_window
    import sram_pkg::*;
(
    input  logic    i_wb_clk,
    input  logic    i_wb_rst,
    // From the bus master
    input  wb_req_t i_req,
    // Towards the controller
    output wb_req_t o_req,
    // Controller response
    input  wb_rsp_t i_rsp,
    // Back to the bus master
    output wb_rsp_t o_rsp
);

    logic [`WB_ADDR_WIDTH-1:0] offset;
    logic                      in_window;
    logic                      req_en;
    logic                      err_r;

    // Offset from the window start
    // Addresses below the base wrap to large values and fail the span test
    assign offset    = i_req.addr - `SRAM_BASE_ADDR;
    assign in_window = offset < `SRAM_ADDR_SPAN;
    assign req_en    = i_req.cyc && i_req.stb;

    // Forward the request rebased to the window start
    // Strobe blocked outside the window so the controller stays idle
    always_comb begin
        o_req      = i_req;
        o_req.addr = offset;
        o_req.stb  = i_req.stb && in_window;
    end

    // One-cycle err for a stray strobe
    // Master still holds stb in the err cycle, so err_r masks a second pulse
    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            err_r <= 1'b0;
        end else begin
            err_r <= req_en && !in_window && !err_r;
        end
    end

    // Controller ack and data pass straight through
    always_comb begin
        o_rsp     = i_rsp;
        o_rsp.err = i_rsp.err || err_r;
    end

endmodule
